// File: build.f
logic/dcache_geom_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_way_store.sv
logic/write_buffer.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tests/tb_clock.sv
tests/dcache_assert.sv
tests/dcache_tb.sv

// File: logic/dcache_ctrl.sv
module dcache_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_req_i,
    input  logic                        cpu_we_i,
    input  dcache_geom_pkg::addr_t      cpu_addr_i,
    input  dcache_geom_pkg::word_t      cpu_wdata_i,
    input  dcache_geom_pkg::wsel_t      cpu_wsel_i,
    input  logic [dcache_geom_pkg::NUM_WAYS-1:0]                   hit_way_i,
    input  dcache_geom_pkg::line_t [dcache_geom_pkg::NUM_WAYS-1:0] rd_line_i,
    input  dcache_geom_pkg::tag_t [dcache_geom_pkg::NUM_WAYS-1:0]  rd_tag_i,
    input  logic                        mem_rvalid_i,
    input  dcache_geom_pkg::line_t      mem_rdata_i,
    input  logic                        wbuf_busy_i,
    input  dcache_geom_pkg::line_addr_t wbuf_addr_i,
    output logic                        cpu_ready_o,
    output logic                        cpu_done_o,
    output dcache_geom_pkg::word_t      cpu_rdata_o,
    output dcache_geom_pkg::index_t     arr_index_o,
    output dcache_geom_pkg::wsel_t [dcache_geom_pkg::NUM_WAYS-1:0] arr_we_o,
    output logic                        arr_line_wide_o,
    output dcache_geom_pkg::word_sel_t  arr_word_o,
    output dcache_geom_pkg::tag_t       arr_tag_o,
    output dcache_geom_pkg::line_t      arr_wline_o,
    output logic                        mem_ren_o,
    output dcache_geom_pkg::line_addr_t mem_araddr_o,
    output logic                        wbuf_push_o,
    output dcache_geom_pkg::line_addr_t wbuf_paddr_o,
    output dcache_geom_pkg::line_t      wbuf_pline_o
);

    dcache_ctrl_pkg::ctrl_state_t state_q;
    dcache_ctrl_pkg::ctrl_state_t state_d;

    // registered request
    dcache_geom_pkg::addr_t req_addr_q;
    logic req_we_q;
    dcache_geom_pkg::word_t req_wdata_q;
    dcache_geom_pkg::wsel_t req_wsel_q;

    dcache_geom_pkg::index_t req_index;
    dcache_geom_pkg::tag_t req_tag;
    dcache_geom_pkg::word_sel_t req_word;
    dcache_geom_pkg::line_addr_t req_line_addr;

    // replacement state
    logic [dcache_geom_pkg::SET_COUNT-1:0] lru_q;
    logic [dcache_geom_pkg::NUM_WAYS-1:0][dcache_geom_pkg::SET_COUNT-1:0] dirty_q;

    dcache_geom_pkg::line_t fill_q;
    dcache_geom_pkg::line_t refill_line;

    logic hit;
    logic hit_sel;
    logic victim;
    logic victim_dirty;
    logic buf_stall;
    logic miss_go;

    assign req_index = dcache_geom_pkg::get_index(req_addr_q);
    assign req_tag = dcache_geom_pkg::get_tag(req_addr_q);
    assign req_word = dcache_geom_pkg::get_word(req_addr_q);
    assign req_line_addr = {req_tag, req_index};

    assign hit = (state_q == dcache_ctrl_pkg::COMPARE) && (|hit_way_i);
    assign hit_sel = hit_way_i[1];
    assign victim = lru_q[req_index];
    assign victim_dirty = dirty_q[victim][req_index];

    // a miss holds while the buffer still owns a line it could collide with
    assign buf_stall = wbuf_busy_i && (victim_dirty || wbuf_addr_i == req_line_addr);
    assign miss_go = ((state_q == dcache_ctrl_pkg::COMPARE && !hit) ||
                      state_q == dcache_ctrl_pkg::WAIT_BUF) && !buf_stall;

    ////////////////////
    // state machine
    ////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_ctrl_pkg::LOOKUP: begin
                if (cpu_req_i) begin
                    state_d = dcache_ctrl_pkg::COMPARE;
                end
            end
            dcache_ctrl_pkg::COMPARE,
            dcache_ctrl_pkg::WAIT_BUF: begin
                if (hit) begin
                    state_d = dcache_ctrl_pkg::LOOKUP;
                end else if (miss_go) begin
                    state_d = dcache_ctrl_pkg::FETCH;
                end else begin
                    state_d = dcache_ctrl_pkg::WAIT_BUF;
                end
            end
            dcache_ctrl_pkg::FETCH: begin
                if (mem_rvalid_i) begin
                    state_d = dcache_ctrl_pkg::REFILL;
                end
            end
            default: begin
                state_d = dcache_ctrl_pkg::LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_ctrl_pkg::LOOKUP;
            req_we_q <= 1'b0;
            lru_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == dcache_ctrl_pkg::LOOKUP && cpu_req_i) begin
                req_we_q <= cpu_we_i;
            end
            // lru names the next victim
            if (hit) begin
                lru_q[req_index] <= ~hit_sel;
            end else if (state_q == dcache_ctrl_pkg::REFILL) begin
                lru_q[req_index] <= ~lru_q[req_index];
            end
            if (hit && req_we_q) begin
                dirty_q[hit_sel][req_index] <= 1'b1;
            end else if (state_q == dcache_ctrl_pkg::REFILL) begin
                dirty_q[victim][req_index] <= req_we_q;
            end
        end
    end

    // request payload and fill line
    always_ff @(posedge clk) begin
        if (state_q == dcache_ctrl_pkg::LOOKUP && cpu_req_i) begin
            req_addr_q <= cpu_addr_i;
            req_wdata_q <= cpu_wdata_i;
            req_wsel_q <= cpu_wsel_i;
        end
        if (state_q == dcache_ctrl_pkg::FETCH && mem_rvalid_i) begin
            fill_q <= mem_rdata_i;
        end
    end

    // write miss lands on top of the fetched line
    always_comb begin
        refill_line = fill_q;
        if (req_we_q) begin
            for (int b = 0; b < $bits(dcache_geom_pkg::wsel_t); b++) begin
                if (req_wsel_q[b]) begin
                    refill_line[req_word][b*8 +: 8] = req_wdata_q[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // array control
    ////////////////////
    assign arr_index_o = (state_q == dcache_ctrl_pkg::LOOKUP) ?
                         dcache_geom_pkg::get_index(cpu_addr_i) : req_index;
    assign arr_line_wide_o = (state_q == dcache_ctrl_pkg::REFILL);
    assign arr_word_o = req_word;
    assign arr_tag_o = req_tag;
    assign arr_wline_o = (state_q == dcache_ctrl_pkg::REFILL) ?
                         refill_line : {dcache_geom_pkg::WORDS_PER_LINE{req_wdata_q}};

    always_comb begin
        arr_we_o = '0;
        if (hit && req_we_q) begin
            arr_we_o[hit_sel] = req_wsel_q;
        end else if (state_q == dcache_ctrl_pkg::REFILL) begin
            arr_we_o[victim] = '1;
        end
    end

    // victim push and memory read
    assign wbuf_push_o = miss_go && victim_dirty;
    assign wbuf_paddr_o = {rd_tag_i[victim], req_index};
    assign wbuf_pline_o = rd_line_i[victim];
    assign mem_ren_o = (state_q == dcache_ctrl_pkg::FETCH);
    assign mem_araddr_o = req_line_addr;

    // cpu response
    assign cpu_ready_o = (state_q == dcache_ctrl_pkg::LOOKUP);
    assign cpu_done_o = hit || (state_q == dcache_ctrl_pkg::REFILL);
    assign cpu_rdata_o = (state_q == dcache_ctrl_pkg::REFILL) ?
                         fill_q[req_word] : rd_line_i[hit_sel][req_word];

endmodule

// File: logic/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    ////////////////////
    // cache controller
    ////////////////////
    // LOOKUP     idle, accepts a request, array read starts
    // COMPARE    tag compare, hits finish here
    // WAIT_BUF   miss held off by a draining victim
    // FETCH      line read from memory
    // REFILL     line written into the victim way
    typedef enum logic [2:0] {
        LOOKUP,
        COMPARE,
        WAIT_BUF,
        FETCH,
        REFILL
    } ctrl_state_t;

    ////////////////////
    // victim write buffer
    ////////////////////
    typedef enum logic {
        EMPTY,
        DRAIN
    } wbuf_state_t;

endpackage

// File: logic/dcache_geom_pkg.sv
package dcache_geom_pkg;

    ////////////////////
    // geometry
    ////////////////////
    localparam int WORDS_PER_LINE = 8;
    localparam int SET_COUNT = 128;
    localparam int NUM_WAYS = 2;

    // field positions inside a byte address
    localparam int TAG_LSB = 12;
    localparam int INDEX_LSB = 5;
    localparam int WORD_LSB = 2;

    ////////////////////
    // types
    ////////////////////
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [19:0] tag_t;
    typedef logic [6:0] index_t;
    typedef logic [2:0] word_sel_t;
    typedef logic [3:0] wsel_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;
    // tag and index together
    typedef logic [26:0] line_addr_t;

    // address split
    function automatic tag_t get_tag(addr_t addr);
        return addr[TAG_LSB +: $bits(tag_t)];
    endfunction

    function automatic index_t get_index(addr_t addr);
        return addr[INDEX_LSB +: $bits(index_t)];
    endfunction

    function automatic word_sel_t get_word(addr_t addr);
        return addr[WORD_LSB +: $bits(word_sel_t)];
    endfunction

endpackage

// File: logic/dcache_top.sv
module dcache_top (
    input  logic                        clk,
    input  logic                        rst,

    // cpu side
    input  logic                        cpu_req_i,
    input  logic                        cpu_we_i,
    input  dcache_geom_pkg::addr_t      cpu_addr_i,
    input  dcache_geom_pkg::word_t      cpu_wdata_i,
    input  dcache_geom_pkg::wsel_t      cpu_wsel_i,
    output logic                        cpu_ready_o,
    output logic                        cpu_done_o,
    output dcache_geom_pkg::word_t      cpu_rdata_o,

    // memory read
    output logic                        mem_ren_o,
    output dcache_geom_pkg::line_addr_t mem_araddr_o,
    input  logic                        mem_rvalid_i,
    input  dcache_geom_pkg::line_t      mem_rdata_i,

    // memory write
    output logic                        mem_wen_o,
    output dcache_geom_pkg::line_addr_t mem_awaddr_o,
    output dcache_geom_pkg::line_t      mem_wdata_o,
    input  logic                        mem_bvalid_i
);

    // array port
    dcache_geom_pkg::index_t arr_index;
    dcache_geom_pkg::wsel_t [dcache_geom_pkg::NUM_WAYS-1:0] arr_we;
    logic arr_line_wide;
    dcache_geom_pkg::word_sel_t arr_word;
    dcache_geom_pkg::tag_t arr_tag;
    dcache_geom_pkg::line_t arr_wline;

    // lookup results
    logic [dcache_geom_pkg::NUM_WAYS-1:0] hit_way;
    dcache_geom_pkg::line_t [dcache_geom_pkg::NUM_WAYS-1:0] rd_line;
    dcache_geom_pkg::tag_t [dcache_geom_pkg::NUM_WAYS-1:0] rd_tag;

    // victim path
    logic wbuf_push;
    dcache_geom_pkg::line_addr_t wbuf_paddr;
    dcache_geom_pkg::line_t wbuf_pline;
    logic wbuf_busy;
    dcache_geom_pkg::line_addr_t wbuf_addr;

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .cpu_req_i       (cpu_req_i),
        .cpu_we_i        (cpu_we_i),
        .cpu_addr_i      (cpu_addr_i),
        .cpu_wdata_i     (cpu_wdata_i),
        .cpu_wsel_i      (cpu_wsel_i),
        .hit_way_i       (hit_way),
        .rd_line_i       (rd_line),
        .rd_tag_i        (rd_tag),
        .mem_rvalid_i    (mem_rvalid_i),
        .mem_rdata_i     (mem_rdata_i),
        .wbuf_busy_i     (wbuf_busy),
        .wbuf_addr_i     (wbuf_addr),
        .cpu_ready_o     (cpu_ready_o),
        .cpu_done_o      (cpu_done_o),
        .cpu_rdata_o     (cpu_rdata_o),
        .arr_index_o     (arr_index),
        .arr_we_o        (arr_we),
        .arr_line_wide_o (arr_line_wide),
        .arr_word_o      (arr_word),
        .arr_tag_o       (arr_tag),
        .arr_wline_o     (arr_wline),
        .mem_ren_o       (mem_ren_o),
        .mem_araddr_o    (mem_araddr_o),
        .wbuf_push_o     (wbuf_push),
        .wbuf_paddr_o    (wbuf_paddr),
        .wbuf_pline_o    (wbuf_pline)
    );

    // tag written on a fill is also the compare tag
    dcache_way_store u_way_store (
        .clk             (clk),
        .rst             (rst),
        .arr_index_i     (arr_index),
        .arr_we_i        (arr_we),
        .arr_line_wide_i (arr_line_wide),
        .arr_word_i      (arr_word),
        .arr_tag_i       (arr_tag),
        .arr_wline_i     (arr_wline),
        .cmp_tag_i       (arr_tag),
        .hit_way_o       (hit_way),
        .rd_line_o       (rd_line),
        .rd_tag_o        (rd_tag)
    );

    write_buffer u_write_buffer (
        .clk          (clk),
        .rst          (rst),
        .push_i       (wbuf_push),
        .push_addr_i  (wbuf_paddr),
        .push_line_i  (wbuf_pline),
        .mem_bvalid_i (mem_bvalid_i),
        .busy_o       (wbuf_busy),
        .addr_o       (wbuf_addr),
        .mem_wen_o    (mem_wen_o),
        .mem_awaddr_o (mem_awaddr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule

// File: logic/dcache_way_store.sv
module dcache_way_store (
    input  logic                       clk,
    input  logic                       rst,
    input  dcache_geom_pkg::index_t    arr_index_i,
    input  dcache_geom_pkg::wsel_t [dcache_geom_pkg::NUM_WAYS-1:0] arr_we_i,
    input  logic                       arr_line_wide_i,
    input  dcache_geom_pkg::word_sel_t arr_word_i,
    input  dcache_geom_pkg::tag_t      arr_tag_i,
    input  dcache_geom_pkg::line_t     arr_wline_i,
    input  dcache_geom_pkg::tag_t      cmp_tag_i,
    output logic [dcache_geom_pkg::NUM_WAYS-1:0]                   hit_way_o,
    output dcache_geom_pkg::line_t [dcache_geom_pkg::NUM_WAYS-1:0] rd_line_o,
    output dcache_geom_pkg::tag_t [dcache_geom_pkg::NUM_WAYS-1:0]  rd_tag_o
);

    for (genvar w = 0; w < dcache_geom_pkg::NUM_WAYS; w++) begin : g_way

        ////////////////////
        // storage
        ////////////////////
        dcache_geom_pkg::line_t data_mem [dcache_geom_pkg::SET_COUNT];
        dcache_geom_pkg::tag_t tag_mem [dcache_geom_pkg::SET_COUNT];
        logic [dcache_geom_pkg::SET_COUNT-1:0] valid_q;

        dcache_geom_pkg::line_t rd_line_q;
        dcache_geom_pkg::tag_t rd_tag_q;
        logic rd_valid_q;

        // byte enables for every word of the line
        dcache_geom_pkg::wsel_t [dcache_geom_pkg::WORDS_PER_LINE-1:0] byte_en;

        // whole line on refill, one word on a write hit
        always_comb begin
            for (int wd = 0; wd < dcache_geom_pkg::WORDS_PER_LINE; wd++) begin
                if (arr_line_wide_i || dcache_geom_pkg::word_sel_t'(wd) == arr_word_i) begin
                    byte_en[wd] = arr_we_i[w];
                end else begin
                    byte_en[wd] = '0;
                end
            end
        end

        // unmasked bytes keep their old content
        always_ff @(posedge clk) begin
            for (int wd = 0; wd < dcache_geom_pkg::WORDS_PER_LINE; wd++) begin
                for (int b = 0; b < $bits(dcache_geom_pkg::wsel_t); b++) begin
                    if (byte_en[wd][b]) begin
                        data_mem[arr_index_i][wd][b*8 +: 8] <= arr_wline_i[wd][b*8 +: 8];
                    end
                end
            end
            if (|arr_we_i[w]) begin
                tag_mem[arr_index_i] <= arr_tag_i;
            end
            // synchronous read port
            rd_line_q <= data_mem[arr_index_i];
            rd_tag_q <= tag_mem[arr_index_i];
        end

        // valid bits
        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q <= '0;
                rd_valid_q <= 1'b0;
            end else begin
                if (|arr_we_i[w]) begin
                    valid_q[arr_index_i] <= 1'b1;
                end
                rd_valid_q <= valid_q[arr_index_i];
            end
        end

        ////////////////////
        // hit detect
        ////////////////////
        assign hit_way_o[w] = rd_valid_q && (rd_tag_q == cmp_tag_i);
        assign rd_line_o[w] = rd_line_q;
        assign rd_tag_o[w] = rd_tag_q;

    end

endmodule

// File: logic/write_buffer.sv
module write_buffer (
    input  logic                        clk,
    input  logic                        rst,

    // victim from the controller
    input  logic                        push_i,
    input  dcache_geom_pkg::line_addr_t push_addr_i,
    input  dcache_geom_pkg::line_t      push_line_i,

    // memory write channel
    input  logic                        mem_bvalid_i,

    output logic                        busy_o,
    output dcache_geom_pkg::line_addr_t addr_o,
    output logic                        mem_wen_o,
    output dcache_geom_pkg::line_addr_t mem_awaddr_o,
    output dcache_geom_pkg::line_t      mem_wdata_o
);

    dcache_ctrl_pkg::wbuf_state_t state_q;

    // the held victim
    dcache_geom_pkg::line_addr_t addr_q;
    dcache_geom_pkg::line_t line_q;

    logic accept;

    // pushes are only taken while empty
    assign accept = (state_q == dcache_ctrl_pkg::EMPTY) && push_i;

    ////////////////////
    // state
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_ctrl_pkg::EMPTY;
        end else begin
            case (state_q)
                dcache_ctrl_pkg::EMPTY: begin
                    if (push_i) begin
                        state_q <= dcache_ctrl_pkg::DRAIN;
                    end
                end
                dcache_ctrl_pkg::DRAIN: begin
                    // write acknowledged
                    if (mem_bvalid_i) begin
                        state_q <= dcache_ctrl_pkg::EMPTY;
                    end
                end
                default: begin
                    state_q <= dcache_ctrl_pkg::EMPTY;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= push_addr_i;
            line_q <= push_line_i;
        end
    end

    ////////////////////
    // outputs
    ////////////////////
    assign busy_o = (state_q == dcache_ctrl_pkg::DRAIN);
    assign addr_o = addr_q;

    // request held for the whole drain
    assign mem_wen_o = (state_q == dcache_ctrl_pkg::DRAIN);
    assign mem_awaddr_o = addr_q;
    assign mem_wdata_o = line_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dcache_tb -Mdir obj_dir -f build.f

./obj_dir/Vdcache_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi

echo "run passed"

// File: tests/dcache_assert.sv
module dcache_assert (
    input logic clk,
    input logic rst,
    input logic cpu_ready_i,
    input logic cpu_done_i,
    input logic mem_ren_i,
    input logic mem_rvalid_i,
    input logic mem_wen_i,
    input logic mem_bvalid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // read request stays up until its line arrives
    ren_held: assert property (@(posedge clk) disable iff (rst)
        mem_ren_i && !mem_rvalid_i |=> mem_ren_i)
    else begin
        $error("mem_ren_o dropped before mem_rvalid_i");
        fail_count++;
    end

    // write request stays up until acknowledged
    wen_held: assert property (@(posedge clk) disable iff (rst)
        mem_wen_i && !mem_bvalid_i |=> mem_wen_i)
    else begin
        $error("mem_wen_o dropped before mem_bvalid_i");
        fail_count++;
    end

    done_not_idle: assert property (@(posedge clk) disable iff (rst)
        !(cpu_done_i && cpu_ready_i))
    else begin
        $error("cpu_done_o high while cpu_ready_o is high");
        fail_count++;
    end

    // no new request during a line fetch
    busy_on_fetch: assert property (@(posedge clk) disable iff (rst)
        mem_ren_i |-> !cpu_ready_i)
    else begin
        $error("cpu_ready_o high while mem_ren_o is high");
        fail_count++;
    end

endmodule

bind dcache_top dcache_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .cpu_ready_i  (cpu_ready_o),
    .cpu_done_i   (cpu_done_o),
    .mem_ren_i    (mem_ren_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wen_i    (mem_wen_o),
    .mem_bvalid_i (mem_bvalid_i)
);

// File: tests/dcache_tb.sv
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // 8 cold, 12 write/read, 5 eviction, 2 latency, 400 random
    localparam int op_total = 427;
    localparam int timeout_cycles = 40 * op_total + 200;
    localparam int random_ops = 400;

    logic clk;
    logic rst;
    logic cpu_req;
    logic cpu_we;
    dcache_geom_pkg::addr_t cpu_addr;
    dcache_geom_pkg::word_t cpu_wdata;
    dcache_geom_pkg::wsel_t cpu_wsel;
    logic cpu_ready;
    logic cpu_done;
    dcache_geom_pkg::word_t cpu_rdata;
    logic mem_ren;
    dcache_geom_pkg::line_addr_t mem_araddr;
    logic mem_rvalid;
    dcache_geom_pkg::line_t mem_rdata;
    logic mem_wen;
    dcache_geom_pkg::line_addr_t mem_awaddr;
    dcache_geom_pkg::line_t mem_wdata;
    logic mem_bvalid;

    integer seed = 32'h07a6b2ce;
    string test_name;
    int error_count = 0;
    int check_count = 0;
    int test_errors = 0;
    int test_ops = 0;
    int wb_count = 0;
    int cycle_count = 0;

    // flat word model and sparse backing memory
    dcache_geom_pkg::word_t model_mem [logic [29:0]];
    dcache_geom_pkg::line_t mem_lines [dcache_geom_pkg::line_addr_t];

    // few tags over few sets keep lines fighting for ways
    dcache_geom_pkg::tag_t tag_pool [4] = '{20'h0a5c1, 20'h13f02, 20'h2b7e4, 20'h3d096};
    dcache_geom_pkg::index_t index_pool [3] = '{7'd3, 7'd4, 7'd5};

    tb_clock u_clock (.clk_o(clk));

    dcache_top dut (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req),
        .cpu_we_i     (cpu_we),
        .cpu_addr_i   (cpu_addr),
        .cpu_wdata_i  (cpu_wdata),
        .cpu_wsel_i   (cpu_wsel),
        .cpu_ready_o  (cpu_ready),
        .cpu_done_o   (cpu_done),
        .cpu_rdata_o  (cpu_rdata),
        .mem_ren_o    (mem_ren),
        .mem_araddr_o (mem_araddr),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata),
        .mem_wen_o    (mem_wen),
        .mem_awaddr_o (mem_awaddr),
        .mem_wdata_o  (mem_wdata),
        .mem_bvalid_i (mem_bvalid)
    );

    ////////////////////
    // reference model
    ////////////////////
    // memory content before any write mixes every address bit
    function automatic dcache_geom_pkg::word_t init_word(input logic [29:0] waddr);
        return {waddr, 2'b00} ^ {waddr[14:0], waddr[29:13]} ^ 32'h6b3e91d4;
    endfunction

    function automatic dcache_geom_pkg::word_t model_read(input dcache_geom_pkg::addr_t addr);
        if (model_mem.exists(addr[31:2])) begin
            return model_mem[addr[31:2]];
        end
        return init_word(addr[31:2]);
    endfunction

    function automatic void model_write(input dcache_geom_pkg::addr_t addr,
                                        input dcache_geom_pkg::word_t data,
                                        input dcache_geom_pkg::wsel_t wsel);
        dcache_geom_pkg::word_t w;
        w = model_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (wsel[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        model_mem[addr[31:2]] = w;
    endfunction

    function automatic dcache_geom_pkg::line_t model_line(input dcache_geom_pkg::line_addr_t la);
        dcache_geom_pkg::line_t l;
        for (int w = 0; w < dcache_geom_pkg::WORDS_PER_LINE; w++) begin
            l[w] = model_read({la, 3'(w), 2'b00});
        end
        return l;
    endfunction

    function automatic dcache_geom_pkg::line_t mem_line(input dcache_geom_pkg::line_addr_t la);
        dcache_geom_pkg::line_t l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int w = 0; w < dcache_geom_pkg::WORDS_PER_LINE; w++) begin
            l[w] = init_word({la, 3'(w)});
        end
        return l;
    endfunction

    function automatic dcache_geom_pkg::addr_t make_addr(input dcache_geom_pkg::tag_t tag,
                                                         input dcache_geom_pkg::index_t index,
                                                         input dcache_geom_pkg::word_sel_t word);
        return {tag, index, word, 2'b00};
    endfunction

    function automatic dcache_geom_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    ////////////////////
    // bookkeeping
    ////////////////////
    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        test_ops = 0;
    endtask

    task automatic finish_test();
        $display("test %s: %0d ops, %0d errors", test_name, test_ops, test_errors);
    endtask

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    ////////////////////
    // cpu side
    ////////////////////
    // latency counts cycles from acceptance to the done pulse
    task automatic access(input logic we, input dcache_geom_pkg::addr_t addr,
                          input dcache_geom_pkg::word_t wdata,
                          input dcache_geom_pkg::wsel_t wsel,
                          output dcache_geom_pkg::word_t rdata, output int latency);
        logic ready_seen;
        cpu_req = 1'b1;
        cpu_we = we;
        cpu_addr = addr;
        cpu_wdata = wdata;
        cpu_wsel = wsel;
        ready_seen = cpu_ready;
        while (!ready_seen) begin
            step();
            ready_seen = cpu_ready;
        end
        step();
        cpu_req = 1'b0;
        latency = 1;
        while (!cpu_done) begin
            step();
            latency++;
        end
        rdata = cpu_rdata;
    endtask

    task automatic read_check(input dcache_geom_pkg::addr_t addr, output int latency);
        dcache_geom_pkg::word_t got;
        dcache_geom_pkg::word_t exp;
        exp = model_read(addr);
        access(1'b0, addr, '0, '0, got, latency);
        check_count++;
        test_ops++;
        if (got !== exp) begin
            $display("** Error %s: read %h expected %h actual %h", test_name, addr, exp, got);
            note_error();
        end
    endtask

    task automatic write_op(input dcache_geom_pkg::addr_t addr,
                            input dcache_geom_pkg::word_t data,
                            input dcache_geom_pkg::wsel_t wsel);
        dcache_geom_pkg::word_t unused_rdata;
        int unused_latency;
        access(1'b1, addr, data, wsel, unused_rdata, unused_latency);
        model_write(addr, data, wsel);
        test_ops++;
    endtask

    // a drained victim must carry every completed write
    task automatic check_write_back(input dcache_geom_pkg::line_addr_t la,
                                    input dcache_geom_pkg::line_t line);
        dcache_geom_pkg::line_t exp;
        exp = model_line(la);
        check_count++;
        wb_count++;
        if (line !== exp) begin
            $display("** Error %s: write-back %h expected %h actual %h",
                     test_name, la, exp, line);
            note_error();
        end
    endtask

    ////////////////////
    // memory responder
    ////////////////////
    initial begin : mem_responder
        int rd_wait;
        int wr_wait;
        logic rd_busy;
        logic wr_busy;
        dcache_geom_pkg::line_addr_t rd_addr;
        dcache_geom_pkg::line_addr_t wr_addr;
        dcache_geom_pkg::line_t wr_line;
        mem_rvalid = 1'b0;
        mem_bvalid = 1'b0;
        mem_rdata = '0;
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        rd_wait = 0;
        wr_wait = 0;
        rd_addr = '0;
        wr_addr = '0;
        wr_line = '0;
        forever begin
            step();
            mem_rvalid = 1'b0;
            mem_bvalid = 1'b0;
            if (!rd_busy && mem_ren && !rst) begin
                rd_busy = 1'b1;
                rd_addr = mem_araddr;
                rd_wait = rand_below(7);
            end
            if (rd_busy) begin
                if (rd_wait == 0) begin
                    mem_rvalid = 1'b1;
                    mem_rdata = mem_line(rd_addr);
                    rd_busy = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
            if (!wr_busy && mem_wen && !rst) begin
                wr_busy = 1'b1;
                wr_wait = rand_below(7);
                wr_addr = mem_awaddr;
                wr_line = mem_wdata;
                check_write_back(mem_awaddr, mem_wdata);
            end
            if (wr_busy) begin
                if (wr_wait == 0) begin
                    mem_bvalid = 1'b1;
                    // backing memory takes the line once the write is acknowledged
                    mem_lines[wr_addr] = wr_line;
                    wr_busy = 1'b0;
                end else begin
                    wr_wait--;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: a request did not finish within %0d cycles", timeout_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin : main_seq
        dcache_geom_pkg::word_t r;
        dcache_geom_pkg::addr_t a;
        dcache_geom_pkg::addr_t a_line;
        dcache_geom_pkg::addr_t b_line;
        dcache_geom_pkg::addr_t c_line;
        int lat;
        int wb_start;
        rst = 1'b1;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_wsel = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("reset");
        check_count++;
        if (!cpu_ready || cpu_done || mem_ren || mem_wen) begin
            $display("** Error %s: ready/done/ren/wen expected 1000 actual %b%b%b%b",
                     test_name, cpu_ready, cpu_done, mem_ren, mem_wen);
            note_error();
        end
        finish_test();

        start_test("cold_read");
        for (int i = 0; i < 8; i++) begin
            a = make_addr(tag_pool[i % 4] ^ 20'h40000, dcache_geom_pkg::index_t'(40 + i),
                          dcache_geom_pkg::word_sel_t'(i));
            read_check(a, lat);
        end
        finish_test();

        start_test("write_read");
        for (int i = 0; i < 6; i++) begin
            r = rand_word();
            a = make_addr(tag_pool[i % 4], dcache_geom_pkg::index_t'(50 + i), r[2:0]);
            write_op(a, rand_word(), r[6:3]);
            read_check(a, lat);
        end
        finish_test();

        // three lines in set 60 leave both ways dirty
        start_test("eviction");
        wb_start = wb_count;
        a_line = make_addr(tag_pool[0], 7'd60, 3'd1);
        b_line = make_addr(tag_pool[1], 7'd60, 3'd4);
        c_line = make_addr(tag_pool[2], 7'd60, 3'd7);
        write_op(a_line, 32'hdead0a0a, 4'b1111);
        write_op(b_line, 32'hbeef0b0b, 4'b0110);
        write_op(c_line, 32'hcafe0c0c, 4'b1001);
        read_check(a_line, lat);
        read_check(b_line, lat);
        check_count++;
        if (wb_count - wb_start != 3) begin
            $display("** Error %s: write-backs expected 3 actual %0d",
                     test_name, wb_count - wb_start);
            note_error();
        end
        finish_test();

        start_test("hit_latency");
        a = make_addr(tag_pool[3], 7'd70, 3'd2);
        read_check(a, lat);
        read_check(a, lat);
        check_count++;
        if (lat != 1) begin
            $display("** Error %s: cycles expected 1 actual %0d", test_name, lat);
            note_error();
        end
        finish_test();

        start_test("random_mix");
        for (int i = 0; i < random_ops; i++) begin
            r = rand_word();
            a = make_addr(tag_pool[rand_below(4)], index_pool[rand_below(3)], r[2:0]);
            if (r[3]) begin
                write_op(a, rand_word(), r[7:4]);
            end else begin
                read_check(a, lat);
            end
        end
        finish_test();

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut.u_assert.fail_count);
        if (error_count == 0 && dut.u_assert.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    localparam int half_period = 10;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(half_period);
            clk_o = ~clk_o;
        end
    end

endmodule
